//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int XLEN            = 64;
  localparam int ADDR_W          = 32;
  localparam int TRANS_ID_W      = 3;
  localparam int BE_W            = XLEN / 8;
  localparam int PAGE_OFF_W      = 12;  // offset bits looked at for hazards
  localparam int STORE_BUF_DEPTH = 4;   // must be a power of two
  localparam int SB_PTR_W        = $clog2(STORE_BUF_DEPTH);

  // ==================================================
  // enums
  // ==================================================
  typedef enum logic [1:0] {
    FU_NONE,
    FU_LOAD,
    FU_STORE
  } fu_e;

  typedef enum logic [3:0] {
    LD, LW, LWU, LH, LHU, LB, LBU,
    SD, SW, SH, SB
  } lsu_op_e;

  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    ST_ADDR_MISALIGNED = 4'd6
  } exc_cause_e;

  // ==================================================
  // structs
  // ==================================================
  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  typedef struct packed {
    fu_e                   fu;
    lsu_op_e               op;
    logic [XLEN-1:0]       operand_a;  // base register
    logic [XLEN-1:0]       operand_b;  // store data
    logic [XLEN-1:0]       imm;
    logic [TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  typedef struct packed {
    logic                  valid;
    logic [ADDR_W-1:0]     vaddr;
    logic [XLEN-1:0]       wdata;  // already on its byte lanes
    logic [BE_W-1:0]       be;
    fu_e                   fu;
    lsu_op_e               op;
    logic [TRANS_ID_W-1:0] trans_id;
  } lsu_ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       data;
    exception_t            ex;
  } lsu_result_t;

  // log2 of the access size in bytes
  function automatic logic [1:0] op_size(lsu_op_e op);
    case (op)
      LD, SD:       return 2'd3;
      LW, LWU, SW:  return 2'd2;
      LH, LHU, SH:  return 2'd1;
      default:      return 2'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;
  import lsu_pkg::*;

  localparam int DMEM_AW = ADDR_W - 3;  // double-word address

  typedef struct packed {
    logic               req;
    logic               we;
    logic [DMEM_AW-1:0] addr;
    logic [BE_W-1:0]    be;
    logic [XLEN-1:0]    wdata;
  } dmem_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;  // read data, one or more cycles after gnt
    logic [XLEN-1:0] rdata;
  } dmem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/lsu_addr_gen.sv
`default_nettype none

module lsu_addr_gen
  import lsu_pkg::*;
(
  input  fu_data_t  fu_data_i,
  input  logic      lsu_valid_i,
  output lsu_ctrl_t ctrl_o
);

  logic [XLEN-1:0] vaddr_full;
  logic [2:0]      offset;
  logic [BE_W-1:0] be_base;

  assign vaddr_full = fu_data_i.operand_a + fu_data_i.imm;
  assign offset     = vaddr_full[2:0];  // byte lane within the double-word

  // unshifted enables for the access size
  always_comb begin
    case (op_size(fu_data_i.op))
      2'd3:    be_base = {BE_W{1'b1}};
      2'd2:    be_base = BE_W'(8'h0f);
      2'd1:    be_base = BE_W'(8'h03);
      default: be_base = BE_W'(8'h01);
    endcase
  end

  always_comb begin
    ctrl_o.valid    = lsu_valid_i;
    ctrl_o.vaddr    = vaddr_full[ADDR_W-1:0];  // physical, upper bits dropped
    ctrl_o.wdata    = fu_data_i.operand_b << {offset, 3'b000};
    ctrl_o.be       = be_base << offset;
    ctrl_o.fu       = fu_data_i.fu;
    ctrl_o.op       = fu_data_i.op;
    ctrl_o.trans_id = fu_data_i.trans_id;
  end

endmodule

`default_nettype wire

//--- hdl/lsu_bypass.sv
`default_nettype none

module lsu_bypass
  import lsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      flush_i,
  input  logic      push_i,
  input  lsu_ctrl_t ctrl_i,
  input  logic      pop_ld_i,
  input  logic      pop_st_i,
  output lsu_ctrl_t head_o,
  output logic      ready_o
);

  lsu_ctrl_t  mem_q [2];
  logic       rd_ptr_q;
  logic       wr_ptr_q;
  logic [1:0] cnt_q;
  logic       pop;

  assign pop     = pop_ld_i | pop_st_i;
  assign ready_o = (cnt_q != 2'd2);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else if (flush_i) begin  // drop everything queued
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push_i) wr_ptr_q <= ~wr_ptr_q;
      if (pop)    rd_ptr_q <= ~rd_ptr_q;
      cnt_q <= cnt_q + 2'(push_i) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= ctrl_i;
  end

  always_comb begin
    head_o       = mem_q[rd_ptr_q];
    head_o.valid = (cnt_q != 2'd0);  // slot contents are stale when empty
  end

  // ==================================================
  // checks
  // ==================================================
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> ready_o);

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pop_ld_i || pop_st_i) |-> head_o.valid && !(pop_ld_i && pop_st_i));

endmodule

`default_nettype wire

//--- hdl/lsu_misalign.sv
`default_nettype none

module lsu_misalign
  import lsu_pkg::*;
(
  input  lsu_ctrl_t  head_i,
  output exception_t ex_o
);

  logic misaligned;

  always_comb begin
    misaligned = 1'b0;
    if (head_i.valid) begin
      case (op_size(head_i.op))
        2'd3:    misaligned = |head_i.vaddr[2:0];
        2'd2:    misaligned = |head_i.vaddr[1:0];
        2'd1:    misaligned = head_i.vaddr[0];
        default: misaligned = 1'b0;  // bytes never fault
      endcase
    end
  end

  always_comb begin
    ex_o.valid = 1'b0;
    ex_o.cause = LD_ADDR_MISALIGNED;
    ex_o.tval  = '0;

    if (misaligned) begin
      case (head_i.fu)
        FU_LOAD: begin
          ex_o.valid = 1'b1;
          ex_o.cause = LD_ADDR_MISALIGNED;
          ex_o.tval  = {{(XLEN - ADDR_W){1'b0}}, head_i.vaddr};
        end
        FU_STORE: begin
          ex_o.valid = 1'b1;
          ex_o.cause = ST_ADDR_MISALIGNED;
          ex_o.tval  = {{(XLEN - ADDR_W){1'b0}}, head_i.vaddr};
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/store_unit.sv
`default_nettype none

module store_unit
  import lsu_pkg::*;
  import mem_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  input  lsu_ctrl_t                 head_i,
  input  exception_t                ex_i,
  output logic                      pop_st_o,
  input  logic                      commit_i,
  output logic                      commit_ready_o,
  output logic                      no_st_pending_o,
  input  logic [PAGE_OFF_W-4:0]     page_offset_i,
  output logic                      page_offset_matches_o,
  output lsu_result_t               result_o,
  output dmem_req_t                 mem_req_o,
  input  dmem_rsp_t                 mem_rsp_i
);

  typedef struct packed {
    logic [DMEM_AW-1:0] addr;
    logic [BE_W-1:0]    be;
    logic [XLEN-1:0]    wdata;
  } sb_entry_t;

  sb_entry_t                  buf_q [STORE_BUF_DEPTH];
  // [issue, commit) committed, [commit, tail) speculative
  logic [SB_PTR_W:0]          issue_ptr_q, commit_ptr_q, tail_ptr_q;
  logic [SB_PTR_W:0]          commit_ptr_d;
  logic [SB_PTR_W:0]          total_cnt;
  logic                       full, push, drain;
  logic [STORE_BUF_DEPTH-1:0] entry_hit;
  logic                       st_valid_q;
  logic [TRANS_ID_W-1:0]      st_trans_id_q;
  exception_t                 st_ex_q;

  assign total_cnt       = tail_ptr_q - issue_ptr_q;
  assign full            = (total_cnt == (SB_PTR_W + 1)'(STORE_BUF_DEPTH));
  assign pop_st_o        = head_i.valid && (head_i.fu == FU_STORE) && !full;
  assign push            = pop_st_o && !ex_i.valid && !flush_i;  // faulting stores stay out
  assign commit_ready_o  = (commit_ptr_q != tail_ptr_q);
  assign no_st_pending_o = (issue_ptr_q == commit_ptr_q);
  assign commit_ptr_d    = commit_ptr_q + (SB_PTR_W + 1)'(commit_i && commit_ready_o);
  assign drain           = !no_st_pending_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      tail_ptr_q   <= '0;
    end else begin
      if (drain && mem_rsp_i.gnt) issue_ptr_q <= issue_ptr_q + 1'b1;
      commit_ptr_q <= commit_ptr_d;
      if (flush_i)   tail_ptr_q <= commit_ptr_d;  // speculative region gone
      else if (push) tail_ptr_q <= tail_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[tail_ptr_q[SB_PTR_W-1:0]] <= '{addr:  head_i.vaddr[ADDR_W-1:3],
                                           be:    head_i.be,
                                           wdata: head_i.wdata};
    end
  end

  // ==================================================
  // hazard match against every live entry
  // ==================================================
  always_comb begin
    logic [SB_PTR_W-1:0] rel;
    for (int i = 0; i < STORE_BUF_DEPTH; i++) begin
      rel          = SB_PTR_W'(i) - issue_ptr_q[SB_PTR_W-1:0];
      entry_hit[i] = ({1'b0, rel} < total_cnt)
                     && (buf_q[i].addr[PAGE_OFF_W-4:0] == page_offset_i);
    end
  end

  assign page_offset_matches_o = |entry_hit;

  // drain port, oldest committed entry
  always_comb begin
    mem_req_o.req   = drain;
    mem_req_o.we    = 1'b1;
    mem_req_o.addr  = buf_q[issue_ptr_q[SB_PTR_W-1:0]].addr;
    mem_req_o.be    = buf_q[issue_ptr_q[SB_PTR_W-1:0]].be;
    mem_req_o.wdata = buf_q[issue_ptr_q[SB_PTR_W-1:0]].wdata;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) st_valid_q <= 1'b0;
    else          st_valid_q <= pop_st_o && !flush_i;
  end

  always_ff @(posedge clk_i) begin
    if (pop_st_o) begin
      st_trans_id_q <= head_i.trans_id;
      st_ex_q       <= ex_i;
    end
  end

  assign result_o = '{valid: st_valid_q, trans_id: st_trans_id_q, data: '0, ex: st_ex_q};

  a_commit_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    commit_i |-> commit_ready_o);

endmodule

`default_nettype wire

//--- hdl/load_unit.sv
`default_nettype none

module load_unit
  import lsu_pkg::*;
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  lsu_ctrl_t             head_i,
  input  exception_t            ex_i,
  output logic                  pop_ld_o,
  output logic [PAGE_OFF_W-4:0] page_offset_o,
  input  logic                  page_offset_matches_i,
  output lsu_result_t           result_o,
  output dmem_req_t             mem_req_o,
  input  dmem_rsp_t             mem_rsp_i
);

  typedef enum logic [1:0] {IDLE, HAZARD, REQ, WAIT_DATA} state_e;

  state_e                state_q, state_d;
  lsu_ctrl_t             ld_q;  // load in flight
  logic                  ld_head, flushed_q;
  logic [XLEN-1:0]       rdata_sh, ld_data;
  logic                  res_valid_q;
  logic [TRANS_ID_W-1:0] res_trans_id_q;
  logic [XLEN-1:0]       res_data_q;
  exception_t            res_ex_q;

  assign ld_head       = head_i.valid && (head_i.fu == FU_LOAD) && !flush_i;
  assign page_offset_o = head_i.vaddr[PAGE_OFF_W-1:3];  // load stays at head until clear

  always_comb begin
    state_d  = state_q;
    pop_ld_o = 1'b0;
    case (state_q)
      IDLE: if (ld_head) begin
        if (ex_i.valid) begin
          pop_ld_o = 1'b1;  // fault reported, no request
        end else if (page_offset_matches_i) begin
          state_d = HAZARD;
        end else begin
          pop_ld_o = 1'b1;
          state_d  = REQ;
        end
      end
      HAZARD: begin
        if (!ld_head) begin
          state_d = IDLE;
        end else if (!page_offset_matches_i) begin
          pop_ld_o = 1'b1;
          state_d  = REQ;
        end
      end
      REQ:       if (mem_rsp_i.gnt)    state_d = WAIT_DATA;
      WAIT_DATA: if (mem_rsp_i.rvalid) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  // ==================================================
  // byte select and extension
  // ==================================================
  assign rdata_sh = mem_rsp_i.rdata >> {ld_q.vaddr[2:0], 3'b000};

  always_comb begin
    case (ld_q.op)
      LW:      ld_data = {{(XLEN - 32){rdata_sh[31]}}, rdata_sh[31:0]};
      LWU:     ld_data = {{(XLEN - 32){1'b0}}, rdata_sh[31:0]};
      LH:      ld_data = {{(XLEN - 16){rdata_sh[15]}}, rdata_sh[15:0]};
      LHU:     ld_data = {{(XLEN - 16){1'b0}}, rdata_sh[15:0]};
      LB:      ld_data = {{(XLEN - 8){rdata_sh[7]}}, rdata_sh[7:0]};
      LBU:     ld_data = {{(XLEN - 8){1'b0}}, rdata_sh[7:0]};
      default: ld_data = rdata_sh;  // LD
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      flushed_q   <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      flushed_q   <= (flushed_q || flush_i) && (state_d != IDLE);  // finish handshake quietly
      res_valid_q <= (pop_ld_o && ex_i.valid)
                     || (state_q == WAIT_DATA && mem_rsp_i.rvalid && !flushed_q && !flush_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_ld_o) ld_q <= head_i;
    if (pop_ld_o && ex_i.valid) begin
      res_trans_id_q <= head_i.trans_id;
      res_data_q     <= '0;
      res_ex_q       <= ex_i;
    end else if (state_q == WAIT_DATA && mem_rsp_i.rvalid) begin
      res_trans_id_q <= ld_q.trans_id;
      res_data_q     <= ld_data;
      res_ex_q       <= '0;
    end
  end

  assign result_o = '{valid: res_valid_q, trans_id: res_trans_id_q,
                      data: res_data_q, ex: res_ex_q};

  always_comb begin
    mem_req_o.req   = (state_q == REQ);
    mem_req_o.we    = 1'b0;
    mem_req_o.addr  = ld_q.vaddr[ADDR_W-1:3];
    mem_req_o.be    = ld_q.be;
    mem_req_o.wdata = '0;
  end

  a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> state_q == WAIT_DATA);

endmodule

`default_nettype wire

//--- hdl/lsu.sv
`default_nettype none

module lsu
  import lsu_pkg::*;
  import mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        flush_i,
  input  fu_data_t    fu_data_i,
  input  logic        lsu_valid_i,
  output logic        lsu_ready_o,
  output lsu_result_t load_result_o,
  output lsu_result_t store_result_o,
  input  logic        commit_i,
  output logic        commit_ready_o,
  output logic        no_st_pending_o,
  output dmem_req_t   ld_mem_req_o,
  input  dmem_rsp_t   ld_mem_rsp_i,
  output dmem_req_t   st_mem_req_o,
  input  dmem_rsp_t   st_mem_rsp_i
);

  lsu_ctrl_t                 ctrl, head;
  exception_t                misalign_ex;
  logic                      push, pop_ld, pop_st;
  logic [PAGE_OFF_W-4:0]     page_offset;
  logic                      page_offset_matches;

  assign push = lsu_valid_i && lsu_ready_o;  // accept strobe

  lsu_addr_gen i_addr_gen (.fu_data_i(fu_data_i), .lsu_valid_i(lsu_valid_i), .ctrl_o(ctrl));

  lsu_bypass i_bypass (
    .clk_i, .rst_n_i, .flush_i,
    .push_i(push), .ctrl_i(ctrl), .pop_ld_i(pop_ld), .pop_st_i(pop_st),
    .head_o(head), .ready_o(lsu_ready_o)
  );

  lsu_misalign i_misalign (.head_i(head), .ex_o(misalign_ex));

  // ==================================================
  // units
  // ==================================================
  store_unit i_store_unit (
    .clk_i, .rst_n_i, .flush_i,
    .head_i(head), .ex_i(misalign_ex), .pop_st_o(pop_st),
    .commit_i, .commit_ready_o, .no_st_pending_o,
    .page_offset_i(page_offset), .page_offset_matches_o(page_offset_matches),
    .result_o(store_result_o), .mem_req_o(st_mem_req_o), .mem_rsp_i(st_mem_rsp_i)
  );

  load_unit i_load_unit (
    .clk_i, .rst_n_i, .flush_i,
    .head_i(head), .ex_i(misalign_ex), .pop_ld_o(pop_ld),
    .page_offset_o(page_offset), .page_offset_matches_i(page_offset_matches),
    .result_o(load_result_o), .mem_req_o(ld_mem_req_o), .mem_rsp_i(ld_mem_rsp_i)
  );

endmodule

`default_nettype wire

//--- tb/lsu_tests.svh
// ==================================================
// stimulus helpers
// ==================================================
task automatic issue(input fu_e fu, input lsu_op_e op, input logic [ADDR_W-1:0] addr,
                     input logic [XLEN-1:0] data);
  pend_t   p;
  st_rec_t s;
  while (!lsu_ready) @(negedge clk);
  fu_data = '{fu: fu, op: op, operand_a: XLEN'(addr) - 64'd24, operand_b: data,
              imm: 64'd24, trans_id: next_id};  // base plus offset gives addr
  lsu_valid = 1'b1;
  p = '{id: next_id, op: op, addr: addr};
  if (fu == FU_LOAD) begin
    ld_exp.push_back(p);
  end else begin
    st_exp.push_back(p);
    if (!misaligned(op, addr)) begin
      s = '{idx: addr[10:3], be: lane_mask(op, addr[2:0]),
            data: data << (8 * addr[2:0])};
      spec_q.push_back(s);
    end
  end
  next_id = next_id + 1'b1;
  @(negedge clk);
  lsu_valid = 1'b0;
endtask

task automatic commit_store();
  st_rec_t s;
  int      n;
  n = 0;
  while (!commit_ready && n < 200) begin
    @(negedge clk);
    n++;
  end
  if (!commit_ready || spec_q.size() == 0) begin
    report_problem("no speculative store was there to commit");
  end else begin
    commit = 1'b1;
    @(negedge clk);
    commit = 1'b0;
    s = spec_q.pop_front();
    ref_mem[s.idx] = apply_bytes(ref_mem[s.idx], s.be, s.data);
  end
endtask

task automatic flush_all();
  flush = 1'b1;
  @(negedge clk);
  flush = 1'b0;
  spec_q.delete();
  ld_exp.delete();  // load in flight is abandoned
endtask

task automatic wait_results();
  int n;
  n = 0;
  while ((ld_exp.size() != 0 || st_exp.size() != 0) && n < 500) begin
    @(posedge clk);
    n++;
  end
  @(negedge clk);
  if (ld_exp.size() != 0 || st_exp.size() != 0)
    report_problem($sformatf("%0d results never arrived", ld_exp.size() + st_exp.size()));
endtask

task automatic wait_drain();
  int n;
  n = 0;
  while (!no_st_pending && n < 500) begin
    @(negedge clk);
    n++;
  end
  if (!no_st_pending) report_problem("committed stores did not drain");
endtask

task automatic start_test(string name);
  cur_test  = name;
  test_errs = errors;
endtask

task automatic end_test();
  wait_results();
  $display("test %-14s %s, %0d errors", cur_test,
           (errors == test_errs) ? "ok" : "bad", errors - test_errs);
endtask

// ==================================================
// directed tests
// ==================================================
task automatic reset_state_test();
  start_test("reset_state");
  check("lsu_ready", 1, lsu_ready);
  check("load valid", 0, load_result.valid);
  check("store valid", 0, store_result.valid);
  check("load req", 0, ld_req.req);
  check("store req", 0, st_req.req);
  check("commit_ready", 0, commit_ready);
  check("no_st_pending", 1, no_st_pending);
  end_test();
endtask

task automatic round_trip_test();
  start_test("round_trip");
  issue(FU_STORE, SD, 32'h100, 64'h1122_3344_5566_7788);
  issue(FU_STORE, SW, 32'h10c, 64'hdead_beef);
  issue(FU_STORE, SH, 32'h112, 64'hcafe);
  issue(FU_STORE, SB, 32'h117, 64'h5a);
  repeat (4) commit_store();
  issue(FU_LOAD, LD, 32'h100, '0);  // may wait on the drain
  issue(FU_LOAD, LD, 32'h108, '0);
  issue(FU_LOAD, LD, 32'h110, '0);
  wait_drain();
  end_test();
endtask

task automatic load_extension_test();
  start_test("load_extension");
  issue(FU_STORE, SD, 32'h200, 64'h8091_a2b3_c4d5_e6f7);
  commit_store();
  wait_drain();
  issue(FU_LOAD, LB, 32'h207, '0);
  issue(FU_LOAD, LBU, 32'h207, '0);
  issue(FU_LOAD, LB, 32'h201, '0);
  issue(FU_LOAD, LBU, 32'h200, '0);
  issue(FU_LOAD, LH, 32'h206, '0);
  issue(FU_LOAD, LHU, 32'h206, '0);
  issue(FU_LOAD, LHU, 32'h202, '0);
  issue(FU_LOAD, LW, 32'h204, '0);
  issue(FU_LOAD, LWU, 32'h204, '0);
  issue(FU_LOAD, LW, 32'h200, '0);
  end_test();
endtask

task automatic misalign_test();
  start_test("misalign");
  issue(FU_LOAD, LD, 32'h301, '0);
  issue(FU_LOAD, LW, 32'h302, '0);
  issue(FU_LOAD, LHU, 32'h305, '0);
  issue(FU_STORE, SD, 32'h304, 64'hffff_ffff_ffff_ffff);
  issue(FU_STORE, SW, 32'h30a, 64'hffff_ffff);
  issue(FU_STORE, SH, 32'h30f, 64'hffff);
  wait_results();
  check("commit_ready", 0, commit_ready);  // faulting stores never buffered
  issue(FU_LOAD, LD, 32'h300, '0);
  issue(FU_LOAD, LD, 32'h308, '0);
  end_test();
endtask

task automatic hazard_test();
  start_test("hazard");
  issue(FU_STORE, SD, 32'h400, 64'h0bad_f00d_1234_5678);
  wait_results();
  issue(FU_LOAD, LD, 32'h400, '0);
  repeat (20) @(negedge clk);
  check("load held", 1, ld_exp.size());
  check("no_st_pending", 1, no_st_pending);
  commit_store();
  check("no_st_pending after commit", 0, no_st_pending);
  wait_drain();
  wait_results();
  end_test();
endtask

task automatic flush_test();
  start_test("flush");
  issue(FU_STORE, SD, 32'h500, 64'h1111_2222_3333_4444);
  issue(FU_STORE, SD, 32'h508, 64'h5555_6666_7777_8888);
  wait_results();
  commit_store();  // only the first survives
  flush_all();
  check("commit_ready", 0, commit_ready);
  wait_drain();
  issue(FU_LOAD, LD, 32'h500, '0);
  issue(FU_LOAD, LD, 32'h508, '0);
  end_test();
endtask

task automatic back_pressure_test();
  start_test("back_pressure");
  ld_hold = 1'b1;
  st_hold = 1'b1;
  issue(FU_STORE, SD, 32'h600, 64'hfeed_face_0000_0001);
  commit_store();
  issue(FU_LOAD, LD, 32'h608, '0);
  issue(FU_LOAD, LW, 32'h610, '0);
  issue(FU_LOAD, LBU, 32'h613, '0);
  check("lsu_ready", 0, lsu_ready);
  check("no_st_pending", 0, no_st_pending);
  ld_hold = 1'b0;
  st_hold = 1'b0;
  issue(FU_LOAD, LH, 32'h61a, '0);
  issue(FU_LOAD, LD, 32'h600, '0);
  issue(FU_LOAD, LHU, 32'h620, '0);
  wait_drain();
  end_test();
endtask

//--- tb/tb_lsu.sv
`default_nettype none

module tb_lsu
  import lsu_pkg::*;
  import mem_pkg::*;
();

  localparam int NUM_TESTS = 7;
  localparam int TEST_TIME = 2000;  // watchdog budget per test
  localparam int MEM_DW    = 256;   // double-words in the memory model

  typedef struct packed {
    logic [TRANS_ID_W-1:0] id;
    lsu_op_e               op;
    logic [ADDR_W-1:0]     addr;
  } pend_t;

  typedef struct packed {
    logic [7:0]      idx;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] data;  // already on its byte lanes
  } st_rec_t;

  logic        clk, rst_n, flush, lsu_valid, commit;
  fu_data_t    fu_data;
  logic        lsu_ready, commit_ready, no_st_pending;
  lsu_result_t load_result, store_result;
  dmem_req_t   ld_req, st_req;
  dmem_rsp_t   ld_rsp, st_rsp;

  logic [XLEN-1:0]       mem [MEM_DW];
  logic [XLEN-1:0]       ref_mem [MEM_DW];  // what loads should see, updated at commit
  pend_t                 ld_exp[$];
  pend_t                 st_exp[$];
  st_rec_t               spec_q[$];         // issued stores not yet committed
  logic [TRANS_ID_W-1:0] next_id;
  logic [31:0]           lfsr;
  logic                  ld_hold, st_hold;  // withhold gnt on a port
  logic                  ld_busy, ld_armed, st_armed;
  int                    ld_wait, st_wait;
  logic [7:0]            ld_idx;
  logic [BE_W-1:0]       ld_be;             // enables seen at the last load gnt
  string                 cur_test;
  int                    checks, errors, test_errs;

  lsu lsu_inst (
    .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush),
    .fu_data_i(fu_data), .lsu_valid_i(lsu_valid), .lsu_ready_o(lsu_ready),
    .load_result_o(load_result), .store_result_o(store_result),
    .commit_i(commit), .commit_ready_o(commit_ready), .no_st_pending_o(no_st_pending),
    .ld_mem_req_o(ld_req), .ld_mem_rsp_i(ld_rsp),
    .st_mem_req_o(st_req), .st_mem_rsp_i(st_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==================================================
  // reference rules
  // ==================================================
  function automatic logic [1:0] access_size(lsu_op_e op);
    case (op)
      LD, SD:      return 2'd3;
      LW, LWU, SW: return 2'd2;
      LH, LHU, SH: return 2'd1;
      default:     return 2'd0;
    endcase
  endfunction

  function automatic logic misaligned(lsu_op_e op, logic [ADDR_W-1:0] addr);
    logic [2:0] mask;
    mask = 3'((1 << access_size(op)) - 1);
    return (addr[2:0] & mask) != 3'd0;
  endfunction

  function automatic logic [BE_W-1:0] lane_mask(lsu_op_e op, logic [2:0] off);
    logic [15:0] m;
    m = 16'((1 << (1 << access_size(op))) - 1) << off;
    return m[BE_W-1:0];
  endfunction

  function automatic logic [XLEN-1:0] apply_bytes(logic [XLEN-1:0] old, logic [BE_W-1:0] be,
                                                  logic [XLEN-1:0] data);
    logic [XLEN-1:0] res;
    res = old;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [XLEN-1:0] load_value(lsu_op_e op, logic [XLEN-1:0] dw,
                                                 logic [2:0] off);
    logic [XLEN-1:0] s;
    s = dw >> (8 * off);
    case (op)
      LW:      return {{32{s[31]}}, s[31:0]};
      LWU:     return {32'h0, s[31:0]};
      LH:      return {{48{s[15]}}, s[15:0]};
      LHU:     return {48'h0, s[15:0]};
      LB:      return {{56{s[7]}}, s[7:0]};
      LBU:     return {56'h0, s[7:0]};
      default: return s;
    endcase
  endfunction

  // galois form, one step per bit taken
  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'hD000_0001;
    return b;
  endfunction

  function automatic int rand_delay();
    int d;
    d = int'(lfsr_bit());
    d = d + 2 * int'(lfsr_bit());
    return d;  // 0 to 3 cycles
  endfunction

  task automatic check(string what, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_problem(string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  // ==================================================
  // memory model, both ports in one process
  // ==================================================
  initial begin
    lfsr   = 32'd96324;
    ld_rsp = '0;
    st_rsp = '0;
    ld_busy  = 1'b0;
    ld_armed = 1'b0;
    st_armed = 1'b0;
    ld_wait  = 0;
    st_wait  = 0;
    ld_be    = '0;
    for (int i = 0; i < MEM_DW; i++) mem[i] = 64'h9e37_79b9_7f4a_7c15 * (i + 1);
    forever begin
      @(negedge clk);
      ld_rsp.gnt    = 1'b0;
      ld_rsp.rvalid = 1'b0;
      st_rsp.gnt    = 1'b0;
      if (ld_busy) begin
        if (ld_wait == 0) begin
          ld_rsp.rvalid = 1'b1;
          ld_rsp.rdata  = mem[ld_idx];
          ld_busy       = 1'b0;
        end else ld_wait--;
      end else if (ld_req.req) begin
        if (!ld_armed) begin
          ld_wait  = rand_delay();
          ld_armed = 1'b1;
        end
        if (ld_wait != 0) ld_wait--;
        else if (!ld_hold) begin
          check("load port we", 0, ld_req.we);
          ld_rsp.gnt = 1'b1;
          ld_idx     = ld_req.addr[7:0];
          ld_be      = ld_req.be;
          ld_busy    = 1'b1;
          ld_armed   = 1'b0;
          ld_wait    = rand_delay();  // rvalid 1 to 4 cycles after gnt
        end
      end
      if (st_req.req) begin
        if (!st_armed) begin
          st_wait  = rand_delay();
          st_armed = 1'b1;
        end
        if (st_wait != 0) st_wait--;
        else if (!st_hold) begin
          check("store port we", 1, st_req.we);
          st_rsp.gnt  = 1'b1;
          st_armed    = 1'b0;
          mem[st_req.addr[7:0]] = apply_bytes(mem[st_req.addr[7:0]], st_req.be, st_req.wdata);
        end
      end
    end
  end

  // ==================================================
  // result monitor
  // ==================================================
  task automatic check_load_result();
    pend_t p;
    if (ld_exp.size() == 0) begin
      report_problem("load result arrived with no load outstanding");
    end else begin
      p = ld_exp.pop_front();
      check("load id", p.id, load_result.trans_id);
      check("load fault", misaligned(p.op, p.addr), load_result.ex.valid);
      if (misaligned(p.op, p.addr)) begin
        check("load cause", LD_ADDR_MISALIGNED, load_result.ex.cause);
        check("load tval", p.addr, load_result.ex.tval);
      end else begin
        check("load data", load_value(p.op, ref_mem[p.addr[10:3]], p.addr[2:0]),
              load_result.data);
        check("load be", lane_mask(p.op, p.addr[2:0]), ld_be);
      end
    end
  endtask

  task automatic check_store_result();
    pend_t p;
    if (st_exp.size() == 0) begin
      report_problem("store result arrived with no store outstanding");
    end else begin
      p = st_exp.pop_front();
      check("store id", p.id, store_result.trans_id);
      check("store fault", misaligned(p.op, p.addr), store_result.ex.valid);
      if (misaligned(p.op, p.addr)) begin
        check("store cause", ST_ADDR_MISALIGNED, store_result.ex.cause);
        check("store tval", p.addr, store_result.ex.tval);
      end
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && load_result.valid) check_load_result();
      if (rst_n && store_result.valid) check_store_result();
    end
  end

  `include "lsu_tests.svh"

  initial begin
    #(NUM_TESTS * TEST_TIME);
    $display("watchdog: run did not finish within %0d time units", NUM_TESTS * TEST_TIME);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    flush     = 1'b0;
    lsu_valid = 1'b0;
    commit    = 1'b0;
    fu_data   = '0;
    ld_hold   = 1'b0;
    st_hold   = 1'b0;
    next_id   = '0;
    checks    = 0;
    errors    = 0;
    cur_test  = "reset";
    for (int i = 0; i < MEM_DW; i++) ref_mem[i] = 64'h9e37_79b9_7f4a_7c15 * (i + 1);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    round_trip_test();
    load_extension_test();
    misalign_test();
    hazard_test();
    flush_test();
    back_pressure_test();

    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) $display("All checks passed");
    else $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+tb
hdl/lsu_pkg.sv
hdl/mem_pkg.sv
hdl/lsu_addr_gen.sv
hdl/lsu_bypass.sv
hdl/lsu_misalign.sv
hdl/store_unit.sv
hdl/load_unit.sv
hdl/lsu.sv
tb/tb_lsu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_lsu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
